// File: dzcpuUcode.f
rtl/ucodePkg.sv
rtl/opcodeFlowLut.sv
rtl/ucodeRom.sv
rtl/flowSequencer.sv
rtl/dzcpuUcode.sv
testbench/tbDzcpuUcode.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the microcode sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tbDzcpuUcode -f dzcpuUcode.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VtbDzcpuUcode)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

// File: testbench/ucodeTestdata.txt
# name zeroFlag byteCount opcodeBytes... wordCount expectedWords...
# All values hex except the two counts, words are {nextAction, operation, operand}
nop             0 1 00    1 0c00
ldrnA           0 1 3e    3 0429 0400 0861
ldrnB           1 1 06    3 0429 0400 0862
ldrnC           0 1 0e    3 0429 0400 0863
incrB           0 1 04    1 1d02
incrC           1 1 0c    1 1d03
decrA           0 1 3d    1 1d21
decrC           1 1 0d    1 1d23
addrB           0 1 80    3 0081 20c2 0ca1
addrC           1 1 81    3 0081 20c3 0ca1
subrB           0 1 90    3 0081 20e2 0ca1
subrC           1 1 91    3 0081 20e3 0ca1
jrn             1 1 18    6 0429 0000 046a 0089 00ca 094b
jrnzZeroSet     1 1 20    3 0429 0000 106a
jrnzZeroClear   0 1 20    6 0429 0000 106a 0089 00ca 094b
jrzZeroClear    0 1 28    3 0429 0000 146a
jrzZeroSet      1 1 28    6 0429 0000 146a 0089 00ca 094b
cbBit7          0 2 cb 7c 4 0429 0000 0560 1980
cbRlrB          1 2 cb 11 4 0429 0000 0560 19a0
cbDefault       0 2 cb 37 4 0429 0000 0560 1dc1
mainDefault     0 1 d3    2 21c1 0c00
nopAfterDefault 1 1 00    1 0c00

// File: testbench/tbDzcpuUcode.sv
module tbDzcpuUcode;
	timeunit 1ns;
	timeprecision 1ps;
	import ucodePkg::*;

	localparam int ResetCycles   = 16;
	localparam int CyclesPerTest = 20;

	logic   clk;
	logic   rstN;
	logic   opValid;
	opcodeT opcode;
	logic   zeroFlag;
	uopT    uop;
	logic   uopValid;
	logic   flowDone;
	logic   busy;

	// Test table from the data file
	string       names[$];
	logic        zeroLevels[$];
	int          byteFirst[$];
	int          byteCount[$];
	opcodeT      bytesQ[$];
	int          wordFirst[$];
	int          wordCount[$];
	logic [13:0] wordsQ[$];

	// Emitted words, flowDone in bit 14
	logic [14:0] seen[$];

	bit          loaded;
	int          passCount;
	int          failCount;
	int unsigned gap;

	dzcpuUcode DUT
	(
		.clk      (clk),
		.rstN     (rstN),
		.opValid  (opValid),
		.opcode   (opcode),
		.zeroFlag (zeroFlag),
		.uop      (uop),
		.uopValid (uopValid),
		.flowDone (flowDone),
		.busy     (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Output monitor on the falling edge
	always @(negedge clk)
	begin
		if (rstN && uopValid)
		begin
			seen.push_back({flowDone, uop});
		end
	end

	////////////////////////////////////////////////////////////
	// Data file
	////////////////////////////////////////////////////////////

	task automatic loadTests();
		int          fd;
		int          code;
		int          ch;
		int          n;
		string       name;
		logic [15:0] val;
		fd = $fopen("testbench/ucodeTestdata.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open testbench/ucodeTestdata.txt");
			failCount++;
		end
		else
		begin
			while ($fscanf(fd, "%s", name) == 1)
			begin
				if (name == "#")
				begin
					// Comment, skip to end of line
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1)
					begin
						ch = $fgetc(fd);
					end
				end
				else
				begin
					code = $fscanf(fd, "%h %d", val, n);
					if (code != 2)
					begin
						$display("Malformed entry for test %s in the data file", name);
						failCount++;
					end
					names.push_back(name);
					zeroLevels.push_back(val[0]);
					byteFirst.push_back(bytesQ.size());
					byteCount.push_back(n);
					repeat (n)
					begin
						code = $fscanf(fd, "%h", val);
						bytesQ.push_back(val[7:0]);
					end
					code = $fscanf(fd, "%d", n);
					wordFirst.push_back(wordsQ.size());
					wordCount.push_back(n);
					repeat (n)
					begin
						code = $fscanf(fd, "%h", val);
						wordsQ.push_back(val[13:0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////////////////////////

	task automatic reportTest(input string name, input int errors);
		if (errors == 0)
		begin
			passCount++;
			$display("PASS %s", name);
		end
		else
		begin
			failCount++;
			$display("FAIL %s with %0d errors", name, errors);
		end
	endtask

	// Called at a falling edge, returns at the falling edge after acceptance
	task automatic sendByte(input opcodeT value);
		while (busy)
		begin
			@(negedge clk);
		end
		@(posedge clk);
		opValid <= 1'b1;
		opcode  <= value;
		@(posedge clk);
		opValid <= 1'b0;
		@(negedge clk);
	endtask

	task automatic checkResetIdle();
		int errors;
		errors = 0;
		repeat (4)
		begin
			@(negedge clk);
			assert (!uopValid && !flowDone && !busy)
			else
			begin
				$display("resetIdle: uopValid, flowDone or busy is high with no opcode sent");
				errors++;
			end
		end
		reportTest("resetIdle", errors);
	endtask

	task automatic runTest(input int t);
		int          errors;
		int          i;
		logic [14:0] got;
		logic [14:0] exp;
		errors = 0;
		assert (seen.size() == 0)
		else
		begin
			$display("%s: %0d micro-ops appeared while idle", names[t], seen.size());
			errors++;
		end
		seen.delete();
		@(posedge clk);
		zeroFlag <= zeroLevels[t];
		@(negedge clk);
		for (i = 0; i < byteCount[t]; i++)
		begin
			sendByte(bytesQ[byteFirst[t] + i]);
		end
		while (busy)
		begin
			@(negedge clk);
		end
		assert (seen.size() == wordCount[t])
		else
		begin
			$display("%s: expected %0d micro-ops but %0d were emitted",
				names[t], wordCount[t], seen.size());
			errors++;
		end
		// flowDone belongs on the final word only
		for (i = 0; i < wordCount[t] && i < seen.size(); i++)
		begin
			exp = {i == wordCount[t] - 1, wordsQ[wordFirst[t] + i]};
			got = seen[i];
			assert (got[13:0] == exp[13:0])
			else
			begin
				$display("ERR %s word %0d: expected %h, actual %h",
					names[t], i, exp[13:0], got[13:0]);
				errors++;
			end
			assert (got[14] == exp[14])
			else
			begin
				$display("ERR %s flowDone on word %0d: expected %b, actual %b",
					names[t], i, exp[14], got[14]);
				errors++;
			end
		end
		seen.delete();
		reportTest(names[t], errors);
	endtask

	initial
	begin
		rstN      = 1'b0;
		opValid   = 1'b0;
		opcode    = '0;
		zeroFlag  = 1'b0;
		passCount = 0;
		failCount = 0;
		loaded    = 1'b0;
		void'($urandom(32'hbc154005));
		loadTests();
		loaded = 1'b1;
		repeat (ResetCycles)
		begin
			@(posedge clk);
		end
		rstN <= 1'b1;
		@(negedge clk);
		checkResetIdle();
		for (int t = 0; t < names.size(); t++)
		begin
			gap = $urandom % 4;
			repeat (gap)
			begin
				@(negedge clk);
			end
			runTest(t);
		end
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		int limit;
		wait (loaded);
		limit = ResetCycles + CyclesPerTest * (names.size() + 1);
		repeat (limit)
		begin
			@(posedge clk);
		end
		$display("Watchdog: run did not finish within %0d cycles, a flow hung", limit);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: rtl/dzcpuUcode.sv
module dzcpuUcode
(
	input  logic             clk,
	input  logic             rstN,
	input  logic             opValid,
	input  ucodePkg::opcodeT opcode,
	input  logic             zeroFlag,
	output ucodePkg::uopT    uop,
	output logic             uopValid,
	output logic             flowDone,
	output logic             busy
);
	import ucodePkg::*;

	opcodeT  lutOpcode;
	logic    cbSelect;
	flowIdxT flowIdx;
	flowIdxT uPc;
	uopT     romUop;

	// Opcode to flow start
	opcodeFlowLut uLut
	(
		.opcode   (lutOpcode),
		.cbSelect (cbSelect),
		.flowIdx  (flowIdx)
	);

	// Microcode store
	ucodeRom uRom
	(
		.uPc    (uPc),
		.romUop (romUop)
	);

	flowSequencer uSeq
	(
		.clk       (clk),
		.rstN      (rstN),
		.opValid   (opValid),
		.opcode    (opcode),
		.zeroFlag  (zeroFlag),
		.flowIdx   (flowIdx),
		.romUop    (romUop),
		.lutOpcode (lutOpcode),
		.cbSelect  (cbSelect),
		.uPc       (uPc),
		.uop       (uop),
		.uopValid  (uopValid),
		.flowDone  (flowDone),
		.busy      (busy)
	);

endmodule

// File: rtl/flowSequencer.sv
module flowSequencer
(
	input  logic              clk,
	input  logic              rstN,
	input  logic              opValid,
	input  ucodePkg::opcodeT  opcode,
	input  logic              zeroFlag,
	input  ucodePkg::flowIdxT flowIdx,
	input  ucodePkg::uopT     romUop,
	output ucodePkg::opcodeT  lutOpcode,
	output logic              cbSelect,
	output ucodePkg::flowIdxT uPc,
	output ucodePkg::uopT     uop,
	output logic              uopValid,
	output logic              flowDone,
	output logic              busy
);
	import ucodePkg::*;

	flowIdxT pcReg;
	logic    cbWait;
	logic    accept;
	logic    eofHit;
	logic    isJcb;
	logic    lastUop;

	assign accept    = opValid && !busy;
	assign lutOpcode = opcode;
	assign cbSelect  = cbWait;

	// First word comes straight from the table, the rest from the counter
	assign uPc = busy ? pcReg : flowIdx;

	////////////////////////////////////////////////////////////
	// End of flow
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (uop.nextAction)
			eof, incEof, eofFu, incEofFu: eofHit = 1'b1;
			incEofZ:                      eofHit = zeroFlag;
			incEofNz:                     eofHit = !zeroFlag;
			default:
			begin
				eofHit = 1'b0;
			end
		endcase
	end

	assign isJcb    = (uop.operation == jcb);
	assign lastUop  = uopValid && (eofHit || isJcb);
	// Prefix word ends the emission but not the instruction
	assign flowDone = uopValid && eofHit && !isJcb;
	assign uopValid = busy;

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy   <= 1'b0;
			cbWait <= 1'b0;
			pcReg  <= '0;
		end
		else if (accept)
		begin
			busy   <= 1'b1;
			cbWait <= 1'b0;
			pcReg  <= uPc + 6'd1;
		end
		else if (lastUop)
		begin
			busy   <= 1'b0;
			cbWait <= isJcb;
		end
		else if (busy)
		begin
			pcReg <= uPc + 6'd1;
		end
	end

	// Output word
	always_ff @(posedge clk)
	begin
		if (accept || (busy && !lastUop))
		begin
			uop <= romUop;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rstN) opValid |-> !busy)
		else $error("opValid while busy");

	// Longest flow in the ROM is six words
	assert property (@(posedge clk) disable iff (!rstN)
		$rose(busy) |-> ##[1:6] !busy)
		else $error("flow ran past six micro-ops");

	// Prefix word must not also mark end of flow
	assert property (@(posedge clk) disable iff (!rstN)
		(uopValid && isJcb) |-> !eofHit)
		else $error("jcb micro-op also marks end of flow");

endmodule

// File: rtl/ucodeRom.sv
module ucodeRom
(
	input  ucodePkg::flowIdxT uPc,
	output ucodePkg::uopT     romUop
);
	import ucodePkg::*;

	// Flow words sit at their start constant plus an offset
	always_comb
	begin
		case (uPc)
			// CB default
			flowCbDefault:          romUop = '{incEofFu, z801bop, a};

			// Default one-byte op
			flowDefault:            romUop = '{updateFlags, z801bop, a};
			flowDefault + 6'd1:     romUop = '{incEof, nop, nullSel};

			// NOP
			flowNop:                romUop = '{incEof, nop, nullSel};

			// LDrn_a
			flowLdrnA:              romUop = '{inc, sma, pc};
			flowLdrnA + 6'd1:       romUop = '{inc, nop, nullSel};
			flowLdrnA + 6'd2:       romUop = '{eof, srm, a};

			// LDrn_b
			flowLdrnB:              romUop = '{inc, sma, pc};
			flowLdrnB + 6'd1:       romUop = '{inc, nop, nullSel};
			flowLdrnB + 6'd2:       romUop = '{eof, srm, b};

			// LDrn_c
			flowLdrnC:              romUop = '{inc, sma, pc};
			flowLdrnC + 6'd1:       romUop = '{inc, nop, nullSel};
			flowLdrnC + 6'd2:       romUop = '{eof, srm, c};

			// INCr_b
			flowIncrB:              romUop = '{incEofFu, inc16, b};

			// INCr_c
			flowIncrC:              romUop = '{incEofFu, inc16, c};

			// DECr_a
			flowDecrA:              romUop = '{incEofFu, dec16, a};

			// DECr_c
			flowDecrC:              romUop = '{incEofFu, dec16, c};

			// ADDr_b
			flowAddrB:              romUop = '{op, sx16r, a};
			flowAddrB + 6'd1:       romUop = '{updateFlags, addx16, b};
			flowAddrB + 6'd2:       romUop = '{incEof, srx16, a};

			// ADDr_c
			flowAddrC:              romUop = '{op, sx16r, a};
			flowAddrC + 6'd1:       romUop = '{updateFlags, addx16, c};
			flowAddrC + 6'd2:       romUop = '{incEof, srx16, a};

			// SUBr_b
			flowSubrB:              romUop = '{op, sx16r, a};
			flowSubrB + 6'd1:       romUop = '{updateFlags, subx16, b};
			flowSubrB + 6'd2:       romUop = '{incEof, srx16, a};

			// SUBr_c
			flowSubrC:              romUop = '{op, sx16r, a};
			flowSubrC + 6'd1:       romUop = '{updateFlags, subx16, c};
			flowSubrC + 6'd2:       romUop = '{incEof, srx16, a};

			// JRn
			flowJrn:                romUop = '{inc, sma, pc};
			flowJrn + 6'd1:         romUop = '{op, nop, nullSel};
			flowJrn + 6'd2:         romUop = '{inc, srm, x8};
			// x16 = pc
			flowJrn + 6'd3:         romUop = '{op, sx16r, pc};
			// x16 = x16 + sign extended x8
			flowJrn + 6'd4:         romUop = '{op, addx16, x8};
			flowJrn + 6'd5:         romUop = '{eof, spc, x16};

			// JRNZn
			flowJrnz:               romUop = '{inc, sma, pc};
			flowJrnz + 6'd1:        romUop = '{op, nop, nullSel};
			// Taken only when zero is clear
			flowJrnz + 6'd2:        romUop = '{incEofZ, srm, x8};
			flowJrnz + 6'd3:        romUop = '{op, sx16r, pc};
			flowJrnz + 6'd4:        romUop = '{op, addx16, x8};
			flowJrnz + 6'd5:        romUop = '{eof, spc, x16};

			// JRZn
			flowJrz:                romUop = '{inc, sma, pc};
			flowJrz + 6'd1:         romUop = '{op, nop, nullSel};
			// Taken only when zero is set
			flowJrz + 6'd2:         romUop = '{incEofNz, srm, x8};
			flowJrz + 6'd3:         romUop = '{op, sx16r, pc};
			flowJrz + 6'd4:         romUop = '{op, addx16, x8};
			flowJrz + 6'd5:         romUop = '{eof, spc, x16};

			// MAPcb, fetches the second byte
			flowMapCb:              romUop = '{inc, sma, pc};
			flowMapCb + 6'd1:       romUop = '{op, nop, nullSel};
			flowMapCb + 6'd2:       romUop = '{inc, jcb, nullSel};

			// CB BIT7
			flowCbBit7:             romUop = '{eofFu, bitTest, nullSel};

			// CB RLr_b
			flowCbRlrB:             romUop = '{eofFu, shl, nullSel};

			default:
			begin
				romUop = '{op, nop, nullSel};
			end
		endcase
	end

endmodule

// File: rtl/opcodeFlowLut.sv
module opcodeFlowLut
(
	input  ucodePkg::opcodeT  opcode,
	input  logic              cbSelect,
	output ucodePkg::flowIdxT flowIdx
);
	import ucodePkg::*;

	flowIdxT mainIdx;
	flowIdxT cbIdx;

	////////////////////////////////////////////////////////////
	// Main opcode table
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			opcNop:   mainIdx = flowNop;
			opcLdrnA: mainIdx = flowLdrnA;
			opcLdrnB: mainIdx = flowLdrnB;
			opcLdrnC: mainIdx = flowLdrnC;
			opcIncrB: mainIdx = flowIncrB;
			opcIncrC: mainIdx = flowIncrC;
			opcDecrA: mainIdx = flowDecrA;
			opcDecrC: mainIdx = flowDecrC;
			opcAddrB: mainIdx = flowAddrB;
			opcAddrC: mainIdx = flowAddrC;
			opcSubrB: mainIdx = flowSubrB;
			opcSubrC: mainIdx = flowSubrC;
			opcJrn:   mainIdx = flowJrn;
			opcJrnz:  mainIdx = flowJrnz;
			opcJrz:   mainIdx = flowJrz;
			// Prefix byte, its flow ends in jcb
			cbPrefix: mainIdx = flowMapCb;
			default:
			begin
				mainIdx = flowDefault;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// CB table, used for the byte after the prefix
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			cbBit7:  cbIdx = flowCbBit7;
			cbRlrB:  cbIdx = flowCbRlrB;
			default:
			begin
				cbIdx = flowCbDefault;
			end
		endcase
	end

	// Table select
	assign flowIdx = cbSelect ? cbIdx : mainIdx;

endmodule

// File: rtl/ucodePkg.sv
package ucodePkg;

	localparam int FlowIdxWidth = 6;

	typedef logic [7:0] opcodeT;
	typedef logic [FlowIdxWidth-1:0] flowIdxT;

	////////////////////////////////////////////////////////////
	// Micro-op fields
	////////////////////////////////////////////////////////////

	// How a micro-op ends or continues its flow
	typedef enum logic [3:0]
	{
		op          = 4'd0,
		inc         = 4'd1,
		eof         = 4'd2,
		incEof      = 4'd3,
		incEofZ     = 4'd4,
		incEofNz    = 4'd5,
		eofFu       = 4'd6,
		incEofFu    = 4'd7,
		updateFlags = 4'd8
	} nextActionE;

	// Operation; bit test and null selector renamed, both are keywords
	typedef enum logic [4:0]
	{
		nop     = 5'd0,
		sma     = 5'd1,
		smw     = 5'd2,
		srm     = 5'd3,
		sx16r   = 5'd4,
		srx16   = 5'd5,
		addx16  = 5'd6,
		subx16  = 5'd7,
		inc16   = 5'd8,
		dec16   = 5'd9,
		spc     = 5'd10,
		jcb     = 5'd11,
		bitTest = 5'd12,
		shl     = 5'd13,
		z801bop = 5'd14
	} operationE;

	// Register or source selector
	typedef enum logic [4:0]
	{
		nullSel = 5'd0,
		a       = 5'd1,
		b       = 5'd2,
		c       = 5'd3,
		d       = 5'd4,
		e       = 5'd5,
		h       = 5'd6,
		l       = 5'd7,
		hl      = 5'd8,
		pc      = 5'd9,
		x8      = 5'd10,
		x16     = 5'd11
	} operandE;

	// 14-bit micro-op word
	typedef struct packed
	{
		nextActionE nextAction;
		operationE  operation;
		operandE    operand;
	} uopT;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	localparam opcodeT cbPrefix = 8'hCB;
	localparam opcodeT opcNop   = 8'h00;
	localparam opcodeT opcIncrB = 8'h04;
	localparam opcodeT opcLdrnB = 8'h06;
	localparam opcodeT opcIncrC = 8'h0C;
	localparam opcodeT opcDecrC = 8'h0D;
	localparam opcodeT opcLdrnC = 8'h0E;
	localparam opcodeT opcJrn   = 8'h18;
	localparam opcodeT opcJrnz  = 8'h20;
	localparam opcodeT opcJrz   = 8'h28;
	localparam opcodeT opcDecrA = 8'h3D;
	localparam opcodeT opcLdrnA = 8'h3E;
	localparam opcodeT opcAddrB = 8'h80;
	localparam opcodeT opcAddrC = 8'h81;
	localparam opcodeT opcSubrB = 8'h90;
	localparam opcodeT opcSubrC = 8'h91;

	// Second byte after the CB prefix
	localparam opcodeT cbRlrB = 8'h11;
	localparam opcodeT cbBit7 = 8'h7C;

	////////////////////////////////////////////////////////////
	// Flow start addresses in the microcode ROM
	////////////////////////////////////////////////////////////

	localparam flowIdxT flowCbDefault = 6'd0;
	localparam flowIdxT flowDefault   = 6'd1;
	localparam flowIdxT flowNop       = 6'd3;
	localparam flowIdxT flowLdrnA     = 6'd4;
	localparam flowIdxT flowLdrnB     = 6'd7;
	localparam flowIdxT flowLdrnC     = 6'd10;
	localparam flowIdxT flowIncrB     = 6'd13;
	localparam flowIdxT flowIncrC     = 6'd14;
	localparam flowIdxT flowDecrA     = 6'd15;
	localparam flowIdxT flowDecrC     = 6'd16;
	localparam flowIdxT flowAddrB     = 6'd17;
	localparam flowIdxT flowAddrC     = 6'd20;
	localparam flowIdxT flowSubrB     = 6'd23;
	localparam flowIdxT flowSubrC     = 6'd26;
	localparam flowIdxT flowJrn       = 6'd29;
	localparam flowIdxT flowJrnz      = 6'd35;
	localparam flowIdxT flowJrz       = 6'd41;
	localparam flowIdxT flowMapCb     = 6'd47;
	localparam flowIdxT flowCbBit7    = 6'd50;
	localparam flowIdxT flowCbRlrB    = 6'd51;

endpackage
